// File: vrc6_pkg.sv
// VRC6 mapper shared definitions
// Bus widths, fixed bank constants, mirroring modes and register selects
`default_nettype none

package vrc6_pkg;

	typedef logic [15:0] cpu_addr_t;
	typedef logic [13:0] ppu_addr_t;
	typedef logic [21:0] ext_addr_t;  // External PRG/CHR memory address
	typedef logic [7:0]  data_t;
	typedef logic [7:0]  chr_bank_t;  // 1 KiB CHR bank
	typedef logic [4:0]  prg_bank8_t; // 16 KiB bank at 8000
	typedef logic [5:0]  prg_bankc_t; // 8 KiB bank at C000

	localparam int FREQ_W = 12; // Channel period width

	localparam logic [8:0] PRG_RAM_BANK  = 9'b111100000; // Work RAM window
	localparam prg_bankc_t PRG_LAST_BANK = 6'b111111;    // Fixed E000 bank
	localparam logic [2:0] CHR_BASE      = 3'b100;

	// Scanline prescaler reloads, alternating 113/113/112
	localparam logic [6:0] IRQ_PRESCALE_LONG  = 7'd113;
	localparam logic [6:0] IRQ_PRESCALE_SHORT = 7'd112;

	typedef enum logic [1:0] {
		MIR_VERT   = 2'd0, // PPU A10
		MIR_HORZ   = 2'd1, // PPU A11
		MIR_ONE_LO = 2'd2,
		MIR_ONE_HI = 2'd3
	} mirror_e;

	// Mapper-24 register map; CHR selects must stay consecutive
	typedef enum logic [4:0] {
		REG_NONE,
		REG_PRG8,
		REG_PRGC,
		REG_MIRROR,
		REG_CHR0, REG_CHR1, REG_CHR2, REG_CHR3,
		REG_CHR4, REG_CHR5, REG_CHR6, REG_CHR7,
		REG_IRQ_LATCH,
		REG_IRQ_CTRL,
		REG_IRQ_ACK,
		REG_SQ1_CTRL, REG_SQ1_FLO, REG_SQ1_FHI,
		REG_SQ2_CTRL, REG_SQ2_FLO, REG_SQ2_FHI,
		REG_SAW_RATE, REG_SAW_FLO, REG_SAW_FHI
	} vrc6_reg_e;

endpackage

`default_nettype wire

// File: vrc6_reg_decode.sv
// VRC6 register decoder
// Maps a CPU write address onto a register select and a write strobe
`default_nettype none

module vrc6_reg_decode import vrc6_pkg::*; (
	input  logic      clk,
	input  logic      ce,
	input  logic      cpu_wr,
	input  cpu_addr_t cpu_addr,
	output vrc6_reg_e reg_sel,
	output logic      wr_stb
);

	logic [1:0] reg_lo;

	assign reg_lo = cpu_addr[1:0];

	always_comb begin
		reg_sel = REG_NONE;
		case (cpu_addr[15:12])
			4'h8: reg_sel = REG_PRG8; // 800x mirrors
			4'h9: case (reg_lo)
				2'd0: reg_sel = REG_SQ1_CTRL;
				2'd1: reg_sel = REG_SQ1_FLO;
				2'd2: reg_sel = REG_SQ1_FHI;
				default: ;
			endcase
			4'hA: case (reg_lo)
				2'd0: reg_sel = REG_SQ2_CTRL;
				2'd1: reg_sel = REG_SQ2_FLO;
				2'd2: reg_sel = REG_SQ2_FHI;
				default: ;
			endcase
			4'hB: case (reg_lo)
				2'd0: reg_sel = REG_SAW_RATE;
				2'd1: reg_sel = REG_SAW_FLO;
				2'd2: reg_sel = REG_SAW_FHI;
				default: reg_sel = REG_MIRROR; // B003
			endcase
			4'hC: reg_sel = REG_PRGC;
			4'hD: reg_sel = vrc6_reg_e'(REG_CHR0 + reg_lo);
			4'hE: reg_sel = vrc6_reg_e'(REG_CHR4 + reg_lo);
			4'hF: case (reg_lo)
				2'd0: reg_sel = REG_IRQ_LATCH;
				2'd1: reg_sel = REG_IRQ_CTRL;
				2'd2: reg_sel = REG_IRQ_ACK;
				default: ;
			endcase
			default: ;
		endcase
	end

	// One strobe per CPU write cycle to a mapped register
	assign wr_stb = ce && cpu_wr && (reg_sel != REG_NONE);

	// Every mapper register sits at 8000 or above
	a_stb_mapped: assert property (@(posedge clk) wr_stb |-> cpu_addr[15]);

endmodule

`default_nettype wire

// File: vrc6_bank_regs.sv
// VRC6 banking registers
// PRG bank, CHR bank and mirroring state written over the CPU bus
`default_nettype none

module vrc6_bank_regs import vrc6_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       wr_stb,
	input  vrc6_reg_e  reg_sel,
	input  data_t      cpu_din,
	output prg_bank8_t prg_bank8,
	output prg_bankc_t prg_bankc,
	output mirror_e    mirror,
	output chr_bank_t  chr_bank [8]
);

	logic       chr_wr;
	logic [2:0] chr_idx;

	assign chr_wr  = wr_stb && (reg_sel >= REG_CHR0) && (reg_sel <= REG_CHR7);
	assign chr_idx = 3'(reg_sel - REG_CHR0); // D000..E003 in order

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prg_bank8 <= '0;
			prg_bankc <= '0;
			mirror    <= MIR_VERT;
		end else if (wr_stb) begin
			case (reg_sel)
				REG_PRG8:   prg_bank8 <= cpu_din[4:0];
				REG_PRGC:   prg_bankc <= cpu_din[5:0];
				REG_MIRROR: mirror    <= mirror_e'(cpu_din[3:2]);
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 8; i++) begin
				chr_bank[i] <= '0;
			end
		end else if (chr_wr) begin
			chr_bank[chr_idx] <= cpu_din; // Full byte per 1 KiB bank
		end
	end

endmodule

`default_nettype wire

// File: vrc6_irq.sv
// VRC6 IRQ counter
// 8-bit up counter clocked per CPU cycle or per scanline through a prescaler
`default_nettype none

module vrc6_irq import vrc6_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      ce,
	input  logic      wr_stb,
	input  vrc6_reg_e reg_sel,
	input  data_t     cpu_din,
	output logic      irq
);

	logic [7:0] latch;
	logic       irq_m;    // Cycle mode
	logic       irq_e;    // Counter enable
	logic       irq_a;    // Enable restored on acknowledge
	logic [6:0] prescale;
	logic [1:0] line;     // Position in the 113/113/112 pattern
	logic [7:0] count;
	logic       timeout;
	logic       ctrl_wr;
	logic       ack_wr;
	logic       step;

	assign ctrl_wr = wr_stb && (reg_sel == REG_IRQ_CTRL);
	assign ack_wr  = wr_stb && (reg_sel == REG_IRQ_ACK);
	assign step    = ce && irq_e && (irq_m || prescale == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			latch <= '0;
			irq_m <= 1'b0;
			irq_a <= 1'b0;
		end else begin
			if (wr_stb && reg_sel == REG_IRQ_LATCH)
				latch <= cpu_din;
			if (ctrl_wr) begin
				irq_m <= cpu_din[2];
				irq_a <= cpu_din[0];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prescale <= '0;
			line     <= '0;
			count    <= '0;
		end else if (ctrl_wr && cpu_din[1]) begin
			prescale <= IRQ_PRESCALE_LONG; // Enabling write restarts everything
			line     <= '0;
			count    <= latch;
		end else if (ce && irq_e) begin
			if (prescale != '0) begin
				prescale <= prescale - 7'd1;
			end else begin
				prescale <= line[1] ? IRQ_PRESCALE_SHORT : IRQ_PRESCALE_LONG;
				line     <= line[1] ? 2'd0 : line + 2'd1;
			end
			if (step)
				count <= (count == 8'hFF) ? latch : count + 8'd1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			irq_e   <= 1'b0;
			timeout <= 1'b0;
		end else begin
			if (ctrl_wr || ack_wr)
				timeout <= 1'b0;
			else if (step && count == 8'hFF)
				timeout <= 1'b1; // Overflow
			if (ctrl_wr)
				irq_e <= cpu_din[1];
			else if (ack_wr)
				irq_e <= irq_a;
		end
	end

	assign irq = timeout & irq_e;

	// Acknowledge drops the request in the next cycle
	a_ack_clears: assert property (@(posedge clk) disable iff (!rst_n) ack_wr |=> !irq);

endmodule

`default_nettype wire

// File: vrc6_pulse.sv
// VRC6 pulse channel
// Volume, 8-step duty cycle or constant digital level, 12-bit period
`default_nettype none

module vrc6_pulse import vrc6_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       ce,
	input  logic       wr_stb,
	input  logic       ctrl_sel,
	input  logic       flo_sel,
	input  logic       fhi_sel,
	input  data_t      cpu_din,
	output logic [3:0] level
);

	logic              mode;     // Digital mode, ignores duty
	logic [2:0]        duty;
	logic [3:0]        vol;
	logic [FREQ_W-1:0] freq;
	logic              en;
	logic [FREQ_W-1:0] div;
	logic [3:0]        duty_cnt;
	logic [4:0]        duty_pos;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			{mode, duty, vol} <= '0;
			freq     <= '0;
			en       <= 1'b0;
			div      <= '0;
			duty_cnt <= '0;
		end else begin
			if (wr_stb && ctrl_sel)
				{mode, duty, vol} <= cpu_din;
			if (wr_stb && flo_sel)
				freq[7:0] <= cpu_din;
			if (wr_stb && fhi_sel)
				{en, freq[FREQ_W-1:8]} <= {cpu_din[7], cpu_din[3:0]};
			if (ce && en) begin
				if (div != '0) begin
					div <= div - 1'b1;
				end else begin
					div      <= freq;
					duty_cnt <= duty_cnt + 4'd1;
				end
			end
		end
	end

	// High phase while the step is at or below the duty setting
	assign duty_pos = {1'b0, duty_cnt} + {1'b0, 1'b1, ~duty};
	assign level    = ((~duty_pos[4] | mode) & en) ? vol : 4'd0;

endmodule

`default_nettype wire

// File: vrc6_saw.sv
// VRC6 sawtooth channel
// Accumulates the rate six times per cycle, cleared on the seventh step
`default_nettype none

module vrc6_saw import vrc6_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       ce,
	input  logic       wr_stb,
	input  vrc6_reg_e  reg_sel,
	input  data_t      cpu_din,
	output logic [4:0] level
);

	logic [5:0]        rate;
	logic [FREQ_W-1:0] freq;
	logic              en;
	logic [FREQ_W:0]   div;  // Runs at half the pulse rate
	logic [2:0]        step;
	logic [7:0]        acc;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rate <= '0;
			freq <= '0;
			en   <= 1'b0;
			div  <= '0;
			step <= '0;
			acc  <= '0;
		end else begin
			if (wr_stb && reg_sel == REG_SAW_RATE)
				rate <= cpu_din[5:0];
			if (wr_stb && reg_sel == REG_SAW_FLO)
				freq[7:0] <= cpu_din;
			if (wr_stb && reg_sel == REG_SAW_FHI)
				{en, freq[FREQ_W-1:8]} <= {cpu_din[7], cpu_din[3:0]};
			if (ce && en) begin
				if (div != '0) begin
					div <= div - 1'b1;
				end else begin
					div <= {freq, 1'b1};
					if (step == 3'd6) begin
						step <= '0;
						acc  <= '0;
					end else begin
						step <= step + 3'd1;
						acc  <= acc + {2'b00, rate};
					end
				end
			end
		end
	end

	assign level = en ? acc[7:3] : 5'd0;

	a_step_range: assert property (@(posedge clk) disable iff (!rst_n) step <= 3'd6);

endmodule

`default_nettype wire

// File: vrc6_addr_map.sv
// VRC6 address translation
// CPU and PPU addresses to PRG, CHR and CIRAM selects, purely combinational
`default_nettype none

module vrc6_addr_map import vrc6_pkg::*; (
	input  cpu_addr_t  cpu_addr,
	input  logic       cpu_wr,
	input  ppu_addr_t  ppu_addr,
	input  prg_bank8_t prg_bank8,
	input  prg_bankc_t prg_bankc,
	input  mirror_e    mirror,
	input  chr_bank_t  chr_bank [8],
	output ext_addr_t  prg_addr,
	output logic       prg_allow,
	output ext_addr_t  chr_addr,
	output logic       ciram_ce,
	output logic       ciram_a10
);

	logic [8:0] prg_hi; // External address bits 21:13
	logic       prg_is_ram;

	assign prg_is_ram = (cpu_addr[15:13] == 3'b011);

	always_comb begin
		case (cpu_addr[15:13])
			3'b011:         prg_hi = PRG_RAM_BANK;
			3'b100, 3'b101: prg_hi = {3'b000, prg_bank8, cpu_addr[13]}; // 16 KiB window
			3'b110:         prg_hi = {3'b000, prg_bankc};
			3'b111:         prg_hi = {3'b000, PRG_LAST_BANK};
			default:        prg_hi = '0;
		endcase
	end

	assign prg_addr  = {prg_hi, cpu_addr[12:0]};
	assign prg_allow = (cpu_addr[15] && !cpu_wr) || prg_is_ram; // ROM read or WRAM

	assign chr_addr = {CHR_BASE, 1'b0, chr_bank[ppu_addr[12:10]], ppu_addr[9:0]};

	assign ciram_ce = ppu_addr[13];

	always_comb begin
		case (mirror)
			MIR_VERT:   ciram_a10 = ppu_addr[10];
			MIR_HORZ:   ciram_a10 = ppu_addr[11];
			MIR_ONE_LO: ciram_a10 = 1'b0;
			default:    ciram_a10 = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

// File: vrc6_top.sv
// VRC6 mapper top level
// Register decode, banking, IRQ, expansion sound and address translation
`default_nettype none

module vrc6_top import vrc6_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       ce,        // One clk pulse per CPU cycle
	input  cpu_addr_t  cpu_addr,
	input  logic       cpu_wr,
	input  data_t      cpu_din,
	input  ppu_addr_t  ppu_addr,
	output ext_addr_t  prg_addr,
	output logic       prg_allow,
	output ext_addr_t  chr_addr,
	output logic       ciram_ce,
	output logic       ciram_a10,
	output logic       irq,
	output logic [5:0] audio
);

	vrc6_reg_e  reg_sel;
	logic       wr_stb;
	prg_bank8_t prg_bank8;
	prg_bankc_t prg_bankc;
	mirror_e    mirror;
	chr_bank_t  chr_bank [8];
	logic [3:0] sq1_level;
	logic [3:0] sq2_level;
	logic [4:0] saw_level;

	vrc6_reg_decode u_decode (
		.clk, .ce, .cpu_wr, .cpu_addr, .reg_sel, .wr_stb
	);

	vrc6_bank_regs u_banks (
		.clk, .rst_n, .wr_stb, .reg_sel, .cpu_din,
		.prg_bank8, .prg_bankc, .mirror, .chr_bank
	);

	vrc6_irq u_irq (
		.clk, .rst_n, .ce, .wr_stb, .reg_sel, .cpu_din, .irq
	);

	vrc6_pulse u_sq1 (
		.clk, .rst_n, .ce, .wr_stb,
		.ctrl_sel (reg_sel == REG_SQ1_CTRL),
		.flo_sel  (reg_sel == REG_SQ1_FLO),
		.fhi_sel  (reg_sel == REG_SQ1_FHI),
		.cpu_din,
		.level    (sq1_level)
	);

	vrc6_pulse u_sq2 (
		.clk, .rst_n, .ce, .wr_stb,
		.ctrl_sel (reg_sel == REG_SQ2_CTRL),
		.flo_sel  (reg_sel == REG_SQ2_FLO),
		.fhi_sel  (reg_sel == REG_SQ2_FHI),
		.cpu_din,
		.level    (sq2_level)
	);

	vrc6_saw u_saw (
		.clk, .rst_n, .ce, .wr_stb, .reg_sel, .cpu_din, .level (saw_level)
	);

	vrc6_addr_map u_map (
		.cpu_addr, .cpu_wr, .ppu_addr, .prg_bank8, .prg_bankc, .mirror, .chr_bank,
		.prg_addr, .prg_allow, .chr_addr, .ciram_ce, .ciram_a10
	);

	// Channels mix as a plain sum, 15 + 15 + 31 fits in six bits
	assign audio = {2'b00, sq1_level} + {2'b00, sq2_level} + {1'b0, saw_level};

endmodule

`default_nettype wire

// File: tb_vrc6_tasks.svh
// VRC6 directed tests
// Bus drivers and one task per checked behavior, included into the testbench
`ifndef TB_VRC6_TASKS_SVH
`define TB_VRC6_TASKS_SVH

// Called on a falling edge, returns on the falling edge after the next ce
task automatic wait_ce();
	bit seen;
	seen = 1'b0;
	for (int n = 0; n < 16 && !seen; n++) begin
		@(posedge clk);
		seen = ce;
	end
	if (!seen) begin
		timeouts++;
		$display("Timeout: no ce pulse within 16 clock cycles at %0t", $time);
	end
	@(negedge clk);
endtask

task automatic cpu_write(input cpu_addr_t addr, input data_t data);
	cpu_addr = addr;
	cpu_din  = data;
	cpu_wr   = 1'b1;
	wait_ce(); // Held across exactly one ce
	cpu_wr   = 1'b0;
endtask

task automatic drive_cpu(input cpu_addr_t addr, input logic wr);
	cpu_addr = addr;
	cpu_wr   = wr;
	@(negedge clk);
endtask

task automatic drive_ppu(input ppu_addr_t addr);
	ppu_addr = addr;
	@(negedge clk);
endtask

task automatic verify_reset_state();
	check_bit("irq", irq, 1'b0);
	check_level("audio", audio, 6'd0);
	drive_cpu(16'hC123, 1'b0); // Bank 0 after reset
	check_addr("prg_addr", prg_addr, 22'h000123);
	check_bit("prg_allow", prg_allow, 1'b1);
	drive_cpu(16'h7000, 1'b1); // Work RAM write
	check_bit("prg_allow", prg_allow, 1'b1);
	check_addr("prg_addr", prg_addr, {9'b111100000, 13'h1000});
	drive_cpu(16'h0000, 1'b0);
endtask

task automatic exercise_prg_banks();
	data_t d8;
	data_t dc;
	d8 = rand_bits(8);
	dc = rand_bits(8);
	cpu_write(16'h8000, d8);
	cpu_write(16'hC000, dc);
	drive_cpu(16'h8456, 1'b0); // Low half of the 16 KiB bank
	check_addr("prg_addr", prg_addr, {3'b000, d8[4:0], 1'b0, 13'h0456});
	drive_cpu(16'hA789, 1'b0);
	check_addr("prg_addr", prg_addr, {3'b000, d8[4:0], 1'b1, 13'h0789});
	drive_cpu(16'hCABC, 1'b0);
	check_addr("prg_addr", prg_addr, {3'b000, dc[5:0], 13'h0ABC});
	drive_cpu(16'hE321, 1'b0);
	check_addr("prg_addr", prg_addr, {3'b000, 6'h3F, 13'h0321});
endtask

task automatic exercise_chr_and_mirror();
	chr_bank_t  banks [8];
	logic [3:0] at_2400;
	logic [3:0] at_2800;
	at_2400 = 4'b1001; // Bit m holds the level for mirror mode m
	at_2800 = 4'b1010;
	for (int i = 0; i < 8; i++) begin
		banks[i] = rand_bits(8);
		cpu_write({(i < 4) ? 4'hD : 4'hE, 10'h000, 2'(i)}, banks[i]);
	end
	for (int r = 0; r < 8; r++) begin
		drive_ppu({1'b0, 3'(r), 10'h155});
		check_addr("chr_addr", chr_addr, {3'b100, 1'b0, banks[r], 10'h155});
	end
	for (int m = 0; m < 4; m++) begin
		cpu_write(16'hB003, {4'h0, 2'(m), 2'b00});
		drive_ppu(14'h2400);
		check_bit("ciram_ce", ciram_ce, 1'b1);
		check_bit("ciram_a10", ciram_a10, at_2400[m]);
		drive_ppu(14'h2800);
		check_bit("ciram_ce", ciram_ce, 1'b1);
		check_bit("ciram_a10", ciram_a10, at_2800[m]);
	end
endtask

// irq low for n - 1 ce, high right after the n-th
task automatic expect_irq_after(input int n);
	for (int i = 1; i <= n; i++) begin
		wait_ce();
		check_bit("irq", irq, i == n);
	end
endtask

task automatic expect_irq_quiet(input int n);
	for (int i = 0; i < n; i++) begin
		wait_ce();
		check_bit("irq", irq, 1'b0);
	end
endtask

task automatic irq_cycle_mode();
	cpu_write(16'hF000, 8'hF0);
	cpu_write(16'hF001, 8'h06); // Cycle mode, enable, no A bit
	expect_irq_after(16);
	cpu_write(16'hF002, 8'h00);
	check_bit("irq", irq, 1'b0);
	expect_irq_quiet(20);
	cpu_write(16'hF001, 8'h07); // Same with A set
	expect_irq_after(16);
	cpu_write(16'hF002, 8'h00);
	check_bit("irq", irq, 1'b0);
	// Next rise is 16 ce after the last one and the acknowledge took one
	expect_irq_after(15);
	cpu_write(16'hF001, 8'h00);
	check_bit("irq", irq, 1'b0);
endtask

task automatic pulse_digital();
	cpu_write(16'h9000, 8'h89); // Digital mode, volume 9
	cpu_write(16'h9002, 8'h80);
	check_level("audio", audio, 6'd9);
	cpu_write(16'hA000, 8'h85);
	cpu_write(16'hA002, 8'h80);
	check_level("audio", audio, 6'd14);
	cpu_write(16'h9002, 8'h00);
	cpu_write(16'hA002, 8'h00);
	check_level("audio", audio, 6'd0);
endtask

task automatic saw_levels();
	int   rate;
	logic in_set;
	logic seen_zero;
	logic seen_top;
	rate      = 8;
	seen_zero = 1'b0;
	seen_top  = 1'b0;
	cpu_write(16'hB000, 8'(rate));
	cpu_write(16'hB001, 8'h00);
	cpu_write(16'hB002, 8'h80);
	for (int n = 0; n < 40; n++) begin
		wait_ce();
		in_set = 1'b0;
		for (int k = 0; k <= 6; k++) begin
			if (audio == 6'((k * rate) >> 3))
				in_set = 1'b1;
		end
		if (!in_set) begin
			errors++;
			$display("ERROR audio = %h, not a sawtooth level at %0t", audio, $time);
		end
		if (audio == 6'd0)
			seen_zero = 1'b1;
		if (audio == 6'((6 * rate) >> 3))
			seen_top = 1'b1;
	end
	if (!seen_zero || !seen_top) begin
		errors++;
		$display("Sawtooth did not sweep its full range within 40 ce");
	end
	cpu_write(16'hB002, 8'h00);
	check_level("audio", audio, 6'd0);
endtask

`endif

// File: tb_vrc6.sv
// VRC6 mapper testbench
// Clock, reset, CE pacing, LFSR stimulus and compare tasks around the DUT
`default_nettype none

module tb_vrc6 import vrc6_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	logic       clk = 1'b0;
	logic       rst_n;
	logic       ce = 1'b0;
	logic [1:0] ce_cnt = 2'd0;
	cpu_addr_t  cpu_addr;
	logic       cpu_wr;
	data_t      cpu_din;
	ppu_addr_t  ppu_addr;
	ext_addr_t  prg_addr;
	logic       prg_allow;
	ext_addr_t  chr_addr;
	logic       ciram_ce;
	logic       ciram_a10;
	logic       irq;
	logic [5:0] audio;

	logic [31:0] lfsr_state;
	int          errors;
	int          timeouts;

	vrc6_top dut0 (
		.clk, .rst_n, .ce, .cpu_addr, .cpu_wr, .cpu_din, .ppu_addr,
		.prg_addr, .prg_allow, .chr_addr, .ciram_ce, .ciram_a10, .irq, .audio
	);

	always #50 clk = ~clk; // 100 ns period

	// One CPU cycle every fourth clk
	always @(negedge clk) begin
		ce_cnt <= ce_cnt + 2'd1;
		ce     <= (ce_cnt == 2'd3);
	end

	// x^32 + x^22 + x^2 + x + 1, new bit enters at bit 0
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic logic [7:0] rand_bits(input int nbits);
		logic [7:0] val;
		val = '0;
		for (int i = 0; i < nbits; i++) begin
			val = {val[6:0], lfsr_step()}; // One step per bit
		end
		return val;
	endfunction

	task automatic check_addr(input string name, input ext_addr_t got, input ext_addr_t exp);
		if (got !== exp) begin
			errors++;
			$display("ERROR %s = %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("ERROR %s = %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_level(input string name, input logic [5:0] got,
			input logic [5:0] exp);
		if (got !== exp) begin
			errors++;
			$display("ERROR %s = %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	`include "tb_vrc6_tasks.svh"

	initial begin
		lfsr_state = 32'h752d;
		errors     = 0;
		timeouts   = 0;
		rst_n      = 1'b0;
		cpu_addr   = '0;
		cpu_wr     = 1'b0;
		cpu_din    = '0;
		ppu_addr   = '0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		verify_reset_state();
		exercise_prg_banks();
		exercise_chr_and_mirror();
		irq_cycle_mode();
		pulse_digital();
		saw_levels();
		$display("Summary: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
vrc6_pkg.sv
vrc6_reg_decode.sv
vrc6_bank_regs.sv
vrc6_irq.sv
vrc6_pulse.sv
vrc6_saw.sv
vrc6_addr_map.sv
vrc6_top.sv
tb_vrc6.sv

// File: run.sh
#!/bin/sh
# Build and run the VRC6 testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	-f verilog.f --top-module tb_vrc6 -o tb_vrc6
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_vrc6 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Test passed$" "$LOG"; then
	exit 0
fi
exit 1
